//--- Makefile
# Verilator build and run of the cpuCore testbench

SOURCES := $(shell cat filelist.f)
BINARY  := obj_dir/VcpuCore_tb

.PHONY: all run clean

all: run

$(BINARY): filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module cpuCore_tb -f filelist.f

run: $(BINARY)
	./$(BINARY) | tee run.log
	grep -q "^Regression passed$$" run.log

clean:
	rm -rf obj_dir run.log

//--- filelist.f
verilog/opcodes.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/programCounter.sv
verilog/control.sv
verilog/cpuCore.sv
sim/busChecker.sv
sim/cpuCore_tb.sv

//--- sim/busChecker.sv
`timescale 1ns/1ps

module busChecker #(
   parameter logic [opcodes::WordWidth-1:0] ResetVector  = '0,
   parameter int                            PatternDepth = 512,
   parameter int                            ListBase     = 256
) (
   input  logic                          Clock,
   input  logic                          nReset,
   input  logic [opcodes::WordWidth-1:0] SysIn,
   input  logic [opcodes::WordWidth-1:0] SysOut,
   input  logic                          ALE,
   input  logic                          nME,
   input  logic                          nOE,
   input  logic                          nWE,
   input  logic                          ENB,
   input  logic [opcodes::WordWidth-1:0] Patterns [PatternDepth],
   output int                            ErrorCount,
   output int                            StoreCount,
   output int                            FetchCount
);

   import opcodes::*;

   logic [WordWidth-1:0] expPc;
   logic [WordWidth-1:0] fetchAddr;
   logic [WordWidth-1:0] linkAddr;
   logic [WordWidth-1:0] dataAddr;
   logic                 wordPending;   // Instruction read still to come
   logic                 dataPending;   // Next ALE carries a load or store address
   logic                 writePrev;
   logic                 writeNow;

   assign writeNow = !nWE && nOE;

   function automatic int mismatch(input string testName, input logic [WordWidth-1:0] expected,
                                   input logic [WordWidth-1:0] actual);
      if (actual === expected) begin
         return 0;
      end
      $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
      return 1;
   endfunction

   always @(posedge Clock or negedge nReset) begin
      int errors;
      int entry;
      if (!nReset) begin
         expPc       <= ResetVector;
         fetchAddr   <= ResetVector;
         linkAddr    <= ResetVector;
         dataAddr    <= '0;
         wordPending <= 1'b0;
         dataPending <= 1'b0;
         writePrev   <= 1'b0;
         ErrorCount  <= 0;
         StoreCount  <= 0;
         FetchCount  <= 0;
      end else begin
         errors = 0;
         // Memory enable level per bus phase
         if (ALE) begin
            errors += mismatch("nME in address cycle", WordWidth'(1), WordWidth'(nME));
         end
         if (ENB) begin
            errors += mismatch("nME in read sample cycle", WordWidth'(0), WordWidth'(nME));
         end
         if (ALE && dataPending) begin
            dataAddr    <= SysOut;
            dataPending <= 1'b0;
         end else if (ALE) begin
            errors += mismatch($sformatf("fetch %0d address", FetchCount), expPc, SysOut);
            fetchAddr   <= SysOut;
            wordPending <= 1'b1;
            FetchCount  <= FetchCount + 1;
         end
         if (ENB && wordPending) begin
            wordPending <= 1'b0;
            case (SysIn[15:11])
               JMP: begin   // PC relative target and link to the next word
                  expPc    <= fetchAddr + {{8{SysIn[7]}}, SysIn[7:0]};
                  linkAddr <= fetchAddr + WordWidth'(1);
               end
               RET:     expPc <= linkAddr;
               default: expPc <= fetchAddr + WordWidth'(1);
            endcase
            if (SysIn[15:11] inside {LDW, STW}) begin
               dataPending <= 1'b1;
            end
         end
         // One compare per write cycle on its first cycle
         if (writeNow && !writePrev) begin
            entry = ListBase + 2 + 2 * StoreCount;
            errors += mismatch($sformatf("store %0d nME", StoreCount),
                               WordWidth'(0), WordWidth'(nME));
            if (StoreCount < int'(Patterns[ListBase])) begin
               errors += mismatch($sformatf("store %0d address", StoreCount),
                                  Patterns[entry], dataAddr);
               errors += mismatch($sformatf("store %0d data", StoreCount),
                                  Patterns[entry + 1], SysOut);
            end else begin
               $display("Unexpected store of %h to address %h after the last expected store",
                        SysOut, dataAddr);
               errors += 1;
            end
            StoreCount <= StoreCount + 1;
         end
         writePrev  <= writeNow;
         ErrorCount <= ErrorCount + errors;
      end
   end

endmodule

//--- sim/cpuCore_tb.sv
`timescale 1ns/1ps

module cpuCore_tb;

   import opcodes::*;

   localparam logic [WordWidth-1:0] ResetVector   = '0;
   localparam int                   MemDepth      = 256;
   localparam int                   PatternDepth  = 512;
   localparam int                   ListBase      = 256;   // Expected list at word 100h
   localparam int                   TimeoutMargin = 50;

   logic                 Clock = 1'b0;
   logic                 nReset = 1'b0;
   logic [WordWidth-1:0] SysIn = '0;
   logic [WordWidth-1:0] SysOut;
   logic                 ALE;
   logic                 nME;
   logic                 nOE;
   logic                 nWE;
   logic                 ENB;
   logic [WordWidth-1:0] patterns [PatternDepth];
   logic [WordWidth-1:0] mem [MemDepth];
   logic [WordWidth-1:0] addrLatch = '0;
   int                   cycleCount = 0;
   int                   errorCount;
   int                   storeCount;
   int                   fetchCount;
   bit                   timedOut = 1'b0;

   cpuCore #(.ResetVector(ResetVector), .RegCount(8)) u_dut (
      .Clock(Clock), .nReset(nReset), .SysIn(SysIn), .SysOut(SysOut),
      .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE), .ENB(ENB)
   );

   busChecker #(.ResetVector(ResetVector), .PatternDepth(PatternDepth),
                .ListBase(ListBase)) u_checker (
      .Clock(Clock), .nReset(nReset), .SysIn(SysIn), .SysOut(SysOut),
      .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE), .ENB(ENB), .Patterns(patterns),
      .ErrorCount(errorCount), .StoreCount(storeCount), .FetchCount(fetchCount)
   );

   always #10 Clock = ~Clock;

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
   end

   // Memory on the strobe bus
   always @(posedge Clock) begin
      if (nReset) begin
         if (ALE) begin
            addrLatch <= SysOut;
         end
         if (!nOE) begin
            SysIn <= mem[addrLatch[7:0]];   // Read data
         end
         if (!nWE && nOE) begin
            mem[addrLatch[7:0]] <= SysOut;
         end
      end
   end

   initial begin
      int expectedStores;
      int cycleLimit;
      for (int i = 0; i < PatternDepth; i++) begin
         patterns[i] = WordWidth'(i) ^ 16'hA500;   // Words the file leaves out
      end
      $readmemh("sim/programPatterns.hex", patterns);
      for (int i = 0; i < MemDepth; i++) begin
         mem[i] <= patterns[i];
      end
      expectedStores = int'(patterns[ListBase]);
      cycleLimit = 9 * int'(patterns[ListBase + 1]) + TimeoutMargin;
      repeat (5) @(posedge Clock);
      nReset <= 1'b1;
      while (storeCount < expectedStores && cycleCount < cycleLimit) begin
         @(posedge Clock);
      end
      if (storeCount < expectedStores) begin
         timedOut = 1'b1;
         $display("Timeout after %0d cycles with only %0d of %0d stores seen",
                  cycleCount, storeCount, expectedStores);
      end else begin
         repeat (20) @(posedge Clock);   // Catch stray stores
      end
      $display("Fetches %0d, stores %0d of %0d, errors %0d, timeouts %0d",
               fetchCount, storeCount, expectedStores, errorCount, int'(timedOut));
      if (errorCount == 0 && !timedOut) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- sim/programPatterns.hex
// From 000: memory image, one instruction or data word per line, then its meaning
// From 100: store count, executed instruction count, then store address and data pairs
@000
3180 // LLI   r1, 80h       store base
2A12 // LUI   r2, 12h
3334 // LLI   r3, 34h
044C // ADD   r4, r2, r3    1234h
4C20 // STW   r4, [r1+0]
0D9D // ADDI  r5, r4, -3    1231h
4D21 // STW   r5, [r1+1]
157F // ADDIB r5, 7Fh       12B0h
1590 // ADDIB r5, 90h       1240h
4D22 // STW   r5, [r1+2]
2EFF // LUI   r6, FFh
02D0 // ADD   r2, r6, r4    1134h with carry out
1B90 // ADC   r3, r4, r4    2469h
4A23 // STW   r2, [r1+3]
4B24 // STW   r3, [r1+4]
02D8 // ADD   r2, r6, r6    FE00h with carry out
2385 // ADCI  r3, r4, 5     123Ah
4B25 // STW   r3, [r1+5]
4730 // LDW   r7, [r1-16]   preloaded word
4F26 // STW   r7, [r1+6]
5004 // JMP   +4            to 18h, link 15h
4223 // LDW   r2, [r1+3]    reads back store 3
4A28 // STW   r2, [r1+8]
5000 // JMP   +0            halt loop
365A // LLI   r6, 5Ah
4E27 // STW   r6, [r1+7]
5800 // RET
@070
BEEF // Preloaded load data
@100
0009 // Stores
001B // Instructions executed
0080 1234
0081 1231
0082 1240
0083 1134
0084 2469
0085 123A
0086 BEEF
0087 005A
0088 1134

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
   input  logic                          Clock,
   input  logic                          nReset,
   input  opcodes::alu_functions_t       AluOp,
   input  logic [opcodes::WordWidth-1:0] Op1,
   input  logic [opcodes::WordWidth-1:0] Op2,
   input  logic                          AluWe,
   input  logic                          AluEn,
   output logic [opcodes::WordWidth-1:0] AluOut,
   output logic [3:0]                    Flags
);

   import opcodes::*;

   logic [WordWidth:0]   sum;
   logic [WordWidth-1:0] result;
   logic [WordWidth-1:0] outReg;
   logic                 carry;
   logic                 zero;
   logic                 negative;
   logic                 overflow;
   logic                 flagUpdate;

   always_comb begin
      sum    = {1'b0, Op1} + {1'b0, Op2};
      result = '0;
      case (AluOp)
         FnADD: result = sum[WordWidth-1:0];
         FnADC: begin
            sum    = {1'b0, Op1} + {1'b0, Op2} + {{WordWidth{1'b0}}, carry};
            result = sum[WordWidth-1:0];
         end
         FnIMM: result = Op2;
         FnMEM: result = Op1;
         default: result = '0;
      endcase
   end

   // Flags follow adds that go straight to the register file
   assign flagUpdate = (AluOp == FnADD || AluOp == FnADC) && !AluWe && !AluEn;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         carry    <= 1'b0;
         zero     <= 1'b0;
         negative <= 1'b0;
         overflow <= 1'b0;
      end else if (flagUpdate) begin
         carry    <= sum[WordWidth];
         zero     <= (result == '0);
         negative <= result[WordWidth-1];
         overflow <= (Op1[WordWidth-1] == Op2[WordWidth-1]) &&
                     (result[WordWidth-1] != Op1[WordWidth-1]);
      end
   end

   always_ff @(posedge Clock) begin
      if (AluWe) begin
         outReg <= result;
      end
   end

   assign AluOut = AluEn ? outReg : result;   // Held value for bus cycles
   assign Flags  = {overflow, negative, carry, zero};

endmodule

//--- verilog/control.sv
`timescale 1ns/1ps

module control (
   output opcodes::alu_functions_t AluOp,
   output opcodes::Op1_select_t    Op1Sel,
   output opcodes::Op2_select_t    Op2Sel,
   output opcodes::Imm_select_t    ImmSel,
   output opcodes::Rs1_select_t    Rs1Sel,
   output opcodes::Wd_select_t     WdSel,
   output opcodes::pc_select_t     PcSel,
   output opcodes::Lr_select_t     LrSel,
   output logic                    AluEn,
   output logic                    AluWe,
   output logic                    LrEn,
   output logic                    LrWe,
   output logic                    PcWe,
   output logic                    PcEn,
   output logic                    IrWe,
   output logic                    RegWe,
   output logic                    MemEn,
   output logic                    nWE,
   output logic                    nOE,
   output logic                    nME,
   output logic                    ENB,
   output logic                    ALE,
   output logic                    CFlag,
   input  logic [7:0]              OpcodeCondIn,
   input  logic [3:0]              Flags,
   input  logic                    Clock,
   input  logic                    nReset
);

   import opcodes::*;

   typedef enum logic {Fetch, Execute} phase_t;
   typedef enum logic [1:0] {Fet1, Fet2, Fet3, Fet4} fetchSub_t;
   typedef enum logic [2:0] {Exe1, Exe2, Exe3, Exe4, Exe5} executeSub_t;

   Opcode_t     opcode;
   phase_t      state;
   fetchSub_t   fetchSub;
   executeSub_t executeSub;
   executeSub_t lastSub;

   assign opcode = Opcode_t'(OpcodeCondIn[7:3]);

   // Length of the execute phase per opcode
   always_comb begin
      case (opcode)
         LDW, STW: lastSub = Exe5;
         JMP:      lastSub = Exe2;
         default:  lastSub = Exe1;   // Single cycle ops and unimplemented codes
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state      <= Fetch;
         fetchSub   <= Fet1;
         executeSub <= Exe1;
      end else if (state == Fetch) begin
         if (fetchSub == Fet4) begin
            state      <= Execute;
            executeSub <= Exe1;
         end
         fetchSub <= fetchSub_t'(fetchSub + 2'd1);   // Wraps to Fet1
      end else if (executeSub == lastSub) begin
         state      <= Fetch;
         fetchSub   <= Fet1;
         executeSub <= Exe1;
      end else begin
         executeSub <= executeSub_t'(executeSub + 3'd1);
      end
   end

   always_comb begin
      AluOp  = FnNOP;
      Op1Sel = Op1Rd1;
      Op2Sel = Op2Imm;
      ImmSel = ImmLong;
      Rs1Sel = Rs1Ra;
      WdSel  = WdAlu;
      PcSel  = Pc1;
      LrSel  = LrSys;
      AluEn  = 1'b0;
      AluWe  = 1'b0;
      LrEn   = 1'b0;
      LrWe   = 1'b0;
      PcWe   = 1'b0;
      PcEn   = 1'b0;
      IrWe   = 1'b0;
      RegWe  = 1'b0;
      MemEn  = 1'b0;
      nWE    = 1'b0;
      nOE    = 1'b0;
      nME    = 1'b0;
      ENB    = 1'b0;
      ALE    = 1'b0;
      CFlag  = 1'b0;
      if (state == Fetch) begin
         case (fetchSub)
            Fet1: begin   // PC out as address
               ALE  = 1'b1;
               nME  = 1'b1;
               nWE  = 1'b1;
               nOE  = 1'b1;
               PcEn = 1'b1;
            end
            Fet2: begin
               nWE   = 1'b1;
               MemEn = 1'b1;
            end
            Fet3: begin   // Sample instruction word
               MemEn = 1'b1;
               ENB   = 1'b1;
               nWE   = 1'b1;
            end
            default: begin
               nME   = 1'b1;
               nWE   = 1'b1;
               MemEn = 1'b1;
               IrWe  = 1'b1;
            end
         endcase
      end else begin
         case (executeSub)
            Exe1: begin
               case (opcode)
                  ADD, ADDI, ADDIB, ADC, ADCI: begin
                     nME   = 1'b1;
                     PcEn  = 1'b1;
                     AluOp = (opcode inside {ADC, ADCI}) ? FnADC : FnADD;
                     CFlag = (opcode inside {ADC, ADCI}) && Flags[1];
                     if (opcode inside {ADD, ADC}) begin
                        Op2Sel = Op2Rd2;
                     end
                     if (opcode != ADDIB) begin
                        ImmSel = ImmShort;
                     end else begin
                        Rs1Sel = Rs1Rd;   // Accumulate into Rd
                     end
                     RegWe = 1'b1;
                     PcWe  = 1'b1;
                  end
                  LUI, LLI: begin
                     nME   = 1'b1;
                     AluOp = FnIMM;
                     RegWe = 1'b1;
                     PcWe  = 1'b1;
                  end
                  LDW, STW: begin   // Address into the output register
                     nME    = 1'b1;
                     ImmSel = ImmShort;
                     AluOp  = FnADD;
                     AluEn  = 1'b1;
                     AluWe  = 1'b1;
                  end
                  JMP: begin
                     AluOp  = FnADD;
                     Op1Sel = Op1Pc;   // PC relative target
                     AluWe  = 1'b1;
                  end
                  RET: begin
                     nME   = 1'b1;
                     PcEn  = 1'b1;
                     LrEn  = 1'b1;
                     PcWe  = 1'b1;
                     PcSel = PcSysbus;
                  end
                  default: ;   // Branches and stack ops
               endcase
            end
            Exe2: begin
               if (opcode inside {LDW, STW}) begin
                  nME   = 1'b1;   // Address latch cycle
                  ALE   = 1'b1;
                  nWE   = 1'b1;
                  nOE   = 1'b1;
                  AluEn = 1'b1;
               end else if (opcode == JMP) begin
                  AluEn = 1'b1;
                  LrWe  = 1'b1;   // Swap target with PC
               end
            end
            Exe3: begin
               if (opcode == LDW) begin
                  MemEn = 1'b1;
                  nWE   = 1'b1;
               end else if (opcode == STW) begin
                  AluOp  = FnMEM;   // Store data from Rd
                  Rs1Sel = Rs1Rd;
                  nOE    = 1'b1;
                  nWE    = 1'b1;
                  AluWe  = 1'b1;
                  AluEn  = 1'b1;
               end
            end
            Exe4: begin
               if (opcode == LDW) begin
                  MemEn = 1'b1;
                  ENB   = 1'b1;
                  nWE   = 1'b1;
               end else if (opcode == STW) begin
                  AluEn = 1'b1;   // Data held on the bus
                  nOE   = 1'b1;
               end
            end
            default: begin
               PcWe = 1'b1;
               if (opcode == LDW) begin
                  nME   = 1'b1;
                  nWE   = 1'b1;
                  MemEn = 1'b1;
                  WdSel = WdSys;
                  RegWe = 1'b1;
               end else begin
                  AluEn = 1'b1;
                  nOE   = 1'b1;
                  nME   = 1'b1;
               end
            end
         endcase
      end
   end

   assert property (@(posedge Clock) disable iff (!nReset) !(IrWe && RegWe));

   // Memory ops keep a fixed five cycle execute phase
   assert property (@(posedge Clock) disable iff (!nReset)
      (state == Execute && executeSub == Exe1 && (opcode inside {LDW, STW}))
         |-> ##1 (executeSub == Exe2) ##1 (executeSub == Exe3)
             ##1 (executeSub == Exe4) ##1 (executeSub == Exe5));

endmodule

//--- verilog/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
   parameter logic [opcodes::WordWidth-1:0] ResetVector = '0,
   parameter int                            RegCount    = 8
) (
   input  logic                          Clock,
   input  logic                          nReset,
   input  logic [opcodes::WordWidth-1:0] SysIn,
   output logic [opcodes::WordWidth-1:0] SysOut,
   output logic                          ALE,
   output logic                          nME,
   output logic                          nOE,
   output logic                          nWE,
   output logic                          ENB
);

   import opcodes::*;

   alu_functions_t       aluOp;
   Op1_select_t          op1Sel;
   Op2_select_t          op2Sel;
   Imm_select_t          immSel;
   Rs1_select_t          rs1Sel;
   Wd_select_t           wdSel;
   pc_select_t           pcSel;
   logic                 aluEn;
   logic                 aluWe;
   logic                 lrEn;
   logic                 lrWe;
   logic                 pcWe;
   logic                 pcEn;
   logic                 irWe;
   logic                 regWe;
   logic                 memEn;
   logic                 cFlag;
   logic [3:0]           flags;
   logic [WordWidth-1:0] ir;
   logic [WordWidth-1:0] readData;
   logic [WordWidth-1:0] imm;
   logic [WordWidth-1:0] rd1;
   logic [WordWidth-1:0] rd2;
   logic [WordWidth-1:0] aluOp1;
   logic [WordWidth-1:0] aluOp2;
   logic [WordWidth-1:0] aluOut;
   logic [WordWidth-1:0] pc;
   logic [WordWidth-1:0] lr;
   Opcode_t              irOpcode;

   always_ff @(posedge Clock) begin
      if (memEn && ENB) begin
         readData <= SysIn;   // Bus sample
      end
      if (irWe) begin
         ir <= readData;
      end
   end

   assign irOpcode = Opcode_t'(ir[15:11]);

   // Immediate extender
   always_comb begin
      if (immSel == ImmShort) begin
         imm = {{(WordWidth-5){ir[4]}}, ir[4:0]};
      end else if (irOpcode == LUI) begin
         imm = {ir[7:0], 8'h00};
      end else if (irOpcode == LLI) begin
         imm = {8'h00, ir[7:0]};
      end else begin
         imm = {{(WordWidth-8){ir[7]}}, ir[7:0]};
      end
   end

   assign aluOp1 = (op1Sel == Op1Pc) ? pc : rd1;
   assign aluOp2 = (op2Sel == Op2Rd2) ? rd2 : imm;
   assign SysOut = pcEn ? pc : aluOut;

   control uControl (
      .AluOp(aluOp), .Op1Sel(op1Sel), .Op2Sel(op2Sel), .ImmSel(immSel),
      .Rs1Sel(rs1Sel), .WdSel(wdSel), .PcSel(pcSel), .LrSel(),
      .AluEn(aluEn), .AluWe(aluWe), .LrEn(lrEn), .LrWe(lrWe),
      .PcWe(pcWe), .PcEn(pcEn), .IrWe(irWe), .RegWe(regWe), .MemEn(memEn),
      .nWE(nWE), .nOE(nOE), .nME(nME), .ENB(ENB), .ALE(ALE), .CFlag(cFlag),
      .OpcodeCondIn(ir[15:8]), .Flags(flags), .Clock(Clock), .nReset(nReset)
   );

   alu uAlu (
      .Clock(Clock), .nReset(nReset), .AluOp(aluOp), .Op1(aluOp1), .Op2(aluOp2),
      .AluWe(aluWe), .AluEn(aluEn), .AluOut(aluOut), .Flags(flags)
   );

   registerFile #(.RegCount(RegCount)) uRegs (
      .Clock(Clock), .nReset(nReset), .RegWe(regWe), .WriteAddr(ir[10:8]),
      .ReadAddr1((rs1Sel == Rs1Rd) ? ir[10:8] : ir[7:5]), .ReadAddr2(ir[4:2]),
      .WdSel(wdSel), .AluResult(aluOut), .SysIn(readData), .Rd1(rd1), .Rd2(rd2)
   );

   programCounter #(.ResetVector(ResetVector)) uPc (
      .Clock(Clock), .nReset(nReset), .PcWe(pcWe), .PcSel(pcSel),
      .LrWe(lrWe), .LrIn(aluOut), .Pc(pc), .Lr(lr)
   );

   // Carry-in from the flag register reaches the adder
   assert property (@(posedge Clock) disable iff (!nReset)
      cFlag |-> aluOut == aluOp1 + aluOp2 + WordWidth'(1));

   // RET resumes at the saved link address
   assert property (@(posedge Clock) disable iff (!nReset)
      lrEn |=> pc == $past(lr));

endmodule

//--- verilog/opcodes.sv
package opcodes;

   localparam int WordWidth = 16;   // Data and address width

   // Major opcode, instruction bits 15..11
   typedef enum logic [4:0] {
      ADD      = 5'b00000,   // Rd = Ra + Rb
      ADDI     = 5'b00001,   // Rd = Ra + simm5
      ADDIB    = 5'b00010,   // Rd = Rd + simm8
      ADC      = 5'b00011,   // Rd = Ra + Rb + C
      ADCI     = 5'b00100,   // Rd = Ra + simm5 + C
      LUI      = 5'b00101,   // Rd = {imm8, 8'h00}
      LLI      = 5'b00110,   // Rd = {8'h00, imm8}
      LDW      = 5'b01000,   // Rd = mem[Ra + simm5]
      STW      = 5'b01001,   // mem[Ra + simm5] = Rd
      JMP      = 5'b01010,   // PC = PC + simm8, LR = PC + 1
      RET      = 5'b01011,   // PC = LR
      BR       = 5'b10000,
      BNE      = 5'b10001,
      BE       = 5'b10010,
      BLT      = 5'b10011,
      BGE      = 5'b10100,
      BWL      = 5'b10101,
      PUSH_POP = 5'b11000
   } Opcode_t;

   typedef enum logic [2:0] {
      FnNOP = 3'd0,
      FnADD = 3'd1,
      FnADC = 3'd2,   // Add with stored carry
      FnIMM = 3'd3,   // Pass operand 2
      FnMEM = 3'd4    // Pass operand 1
   } alu_functions_t;

   typedef enum logic {
      Op1Rd1 = 1'b0,
      Op1Pc  = 1'b1
   } Op1_select_t;

   typedef enum logic {
      Op2Rd2 = 1'b0,
      Op2Imm = 1'b1
   } Op2_select_t;

   typedef enum logic {
      ImmShort = 1'b0,   // Signed bits 4..0
      ImmLong  = 1'b1    // Bits 7..0
   } Imm_select_t;

   typedef enum logic {
      WdAlu = 1'b0,
      WdSys = 1'b1       // Read data from the bus
   } Wd_select_t;

   typedef enum logic {
      Rs1Ra = 1'b0,      // Bits 7..5
      Rs1Rd = 1'b1       // Bits 10..8
   } Rs1_select_t;

   typedef enum logic {
      Pc1      = 1'b0,
      PcSysbus = 1'b1
   } pc_select_t;

   typedef enum logic {
      LrSys = 1'b0       // Capture next PC
   } Lr_select_t;

endpackage

//--- verilog/programCounter.sv
`timescale 1ns/1ps

module programCounter #(
   parameter logic [opcodes::WordWidth-1:0] ResetVector = '0
) (
   input  logic                          Clock,
   input  logic                          nReset,
   input  logic                          PcWe,
   input  opcodes::pc_select_t           PcSel,
   input  logic                          LrWe,
   input  logic [opcodes::WordWidth-1:0] LrIn,
   output logic [opcodes::WordWidth-1:0] Pc,
   output logic [opcodes::WordWidth-1:0] Lr
);

   import opcodes::*;

   logic [WordWidth-1:0] pcInc;

   assign pcInc = Pc + WordWidth'(1);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Pc <= ResetVector;
         Lr <= ResetVector;
      end else if (LrWe) begin
         // Jump: target into PC, return address into LR
         Pc <= LrIn;
         Lr <= pcInc;
      end else if (PcWe) begin
         if (PcSel == Pc1) begin
            Pc <= pcInc;
         end else begin
            Pc <= Lr;   // Return
         end
      end
   end

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
   parameter int RegCount = 8
) (
   input  logic                          Clock,
   input  logic                          nReset,
   input  logic                          RegWe,
   input  logic [2:0]                    WriteAddr,
   input  logic [2:0]                    ReadAddr1,
   input  logic [2:0]                    ReadAddr2,
   input  opcodes::Wd_select_t           WdSel,
   input  logic [opcodes::WordWidth-1:0] AluResult,
   input  logic [opcodes::WordWidth-1:0] SysIn,
   output logic [opcodes::WordWidth-1:0] Rd1,
   output logic [opcodes::WordWidth-1:0] Rd2
);

   import opcodes::*;

   logic [WordWidth-1:0] regs [RegCount];
   logic [WordWidth-1:0] writeData;

   assign writeData = (WdSel == WdSys) ? SysIn : AluResult;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (RegWe) begin
         regs[WriteAddr] <= writeData;
      end
   end

   // R0 is hardwired to zero on reads
   assign Rd1 = (ReadAddr1 == 3'd0) ? '0 : regs[ReadAddr1];
   assign Rd2 = (ReadAddr2 == 3'd0) ? '0 : regs[ReadAddr2];

   assert property (@(posedge Clock) disable iff (!nReset)
      RegWe |-> !$isunknown(WriteAddr));

endmodule
